//--- design/mips_pkg.sv
package mips_pkg;

    // ######################################
    // widths shared across the core
    // ######################################

    localparam int DATA_W    = 32;  // data and address word
    localparam int REG_IDX_W = 5;   // register index
    localparam int BE_W      = 4;   // byte enable, one bit per byte lane
    localparam int NUM_REGS  = 32;

    // byte distance between two consecutive instructions
    localparam logic [DATA_W-1:0] WORD_BYTES = 32'd4;

    // ######################################
    // address constants
    // ######################################

    localparam logic [DATA_W-1:0] RESET_VECTOR = 32'h0000_0004;  // first fetch after reset
    localparam logic [DATA_W-1:0] HALT_ADDR    = 32'h0000_0000;  // jumping here stops the core

    localparam logic [REG_IDX_W-1:0] REG_V0 = 5'd2;  // result register seen by the testbench

    // ######################################
    // instruction encodings
    // ######################################

    // primary opcode, bits 31:26 of the instruction
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,  // R-type, operation given by funct
        BLEZ    = 6'h06,
        BGTZ    = 6'h07,
        ADDIU   = 6'h09,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        SLL  = 6'h00,  // all-zero word is the NOP
        JR   = 6'h08,
        ADDU = 6'h21
    } funct_e;

    // ######################################
    // controller states
    // ######################################

    typedef enum logic [2:0] {
        IDLE,   // out of reset, waiting one cycle before the first fetch
        FETCH,  // instruction read on the Avalon port
        EXEC,   // decode, ALU write-back and PC update
        MEM,    // data read or write for LW and SW
        HALT    // parked after a jump to HALT_ADDR
    } cpu_state_e;

endpackage

//--- design/reg_file.sv
module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mips_pkg::REG_IDX_W-1:0] rs_idx,
    input  logic [mips_pkg::REG_IDX_W-1:0] rt_idx,
    input  logic                           wr_en,
    input  logic [mips_pkg::REG_IDX_W-1:0] wr_idx,
    input  logic [mips_pkg::DATA_W-1:0]    wr_data,
    output logic [mips_pkg::DATA_W-1:0]    rs_val,
    output logic [mips_pkg::DATA_W-1:0]    rt_val,
    output logic [mips_pkg::DATA_W-1:0]    register_v0
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // ######################################
    // single write port
    // ######################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin  // $zero is hard-wired
            regs[wr_idx] <= wr_data;
        end
    end

    // two asynchronous read ports
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    // v0 is brought out so a test can see the result after the core halts
    assign register_v0 = regs[REG_V0];

    assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

//--- design/alu_branch.sv
module alu_branch (
    input  logic [mips_pkg::DATA_W-1:0]    instr,
    input  logic [mips_pkg::DATA_W-1:0]    pc,
    input  logic [mips_pkg::DATA_W-1:0]    rs_val,
    input  logic [mips_pkg::DATA_W-1:0]    rt_val,
    output logic [mips_pkg::DATA_W-1:0]    alu_result,
    output logic [mips_pkg::DATA_W-1:0]    mem_addr,
    output logic [mips_pkg::REG_IDX_W-1:0] dest_idx,
    output logic                           writes_reg,
    output logic                           is_load,
    output logic                           is_store,
    output logic                           take_branch,
    output logic [mips_pkg::DATA_W-1:0]    branch_target
);
    import mips_pkg::*;

    opcode_e              opcode;
    funct_e               funct;
    logic [REG_IDX_W-1:0] rt_field;
    logic [REG_IDX_W-1:0] rd_field;
    logic [4:0]           shamt;
    logic [DATA_W-1:0]    imm_sext;
    logic [DATA_W-1:0]    rel_target;
    logic                 rs_le_zero;

    // ######################################
    // field extraction
    // ######################################

    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign rt_field = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};

    // offset counts words from the delay slot
    assign rel_target = pc + WORD_BYTES + {imm_sext[DATA_W-3:0], 2'b00};

    assign rs_le_zero = rs_val[DATA_W-1] || (rs_val == '0);  // signed compare against zero

    assign mem_addr = rs_val + imm_sext;  // base plus offset for LW and SW

    // ######################################
    // decode and execute
    // ######################################

    always_comb begin
        alu_result    = '0;
        dest_idx      = rt_field;
        writes_reg    = 1'b0;
        is_load       = 1'b0;
        is_store      = 1'b0;
        take_branch   = 1'b0;
        branch_target = rel_target;

        case (opcode)
            SPECIAL: begin
                dest_idx = rd_field;
                case (funct)
                    SLL: begin
                        alu_result = rt_val << shamt;
                        writes_reg = 1'b1;
                    end
                    ADDU: begin
                        alu_result = rs_val + rt_val;  // no overflow trap
                        writes_reg = 1'b1;
                    end
                    JR: begin
                        take_branch   = 1'b1;
                        branch_target = rs_val;
                    end
                    default: begin
                        writes_reg = 1'b0;  // unsupported funct acts as a NOP
                    end
                endcase
            end
            ADDIU: begin
                alu_result = rs_val + imm_sext;
                writes_reg = 1'b1;
            end
            BLEZ: take_branch = rs_le_zero;
            BGTZ: take_branch = !rs_le_zero;
            LW: begin
                is_load    = 1'b1;
                writes_reg = 1'b1;
            end
            SW: is_store = 1'b1;
            default: begin
                writes_reg = 1'b0;
            end
        endcase
    end

endmodule

//--- design/cpu_control.sv
module cpu_control (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           waitrequest,
    input  logic [mips_pkg::DATA_W-1:0]    readdata,
    input  logic [mips_pkg::DATA_W-1:0]    rs_val,
    input  logic [mips_pkg::DATA_W-1:0]    rt_val,
    input  logic [mips_pkg::DATA_W-1:0]    alu_result,
    input  logic [mips_pkg::DATA_W-1:0]    mem_addr,
    input  logic [mips_pkg::REG_IDX_W-1:0] dest_idx,
    input  logic                           writes_reg,
    input  logic                           is_load,
    input  logic                           is_store,
    input  logic                           take_branch,
    input  logic [mips_pkg::DATA_W-1:0]    branch_target,
    output logic                           active,
    output logic [mips_pkg::DATA_W-1:0]    address,
    output logic                           read,
    output logic                           write,
    output logic [mips_pkg::DATA_W-1:0]    writedata,
    output logic [mips_pkg::BE_W-1:0]      byteenable,
    output logic [mips_pkg::DATA_W-1:0]    instr,
    output logic [mips_pkg::DATA_W-1:0]    pc,
    output logic [mips_pkg::REG_IDX_W-1:0] rs_idx,
    output logic [mips_pkg::REG_IDX_W-1:0] rt_idx,
    output logic                           wr_en,
    output logic [mips_pkg::REG_IDX_W-1:0] wr_idx,
    output logic [mips_pkg::DATA_W-1:0]    wr_data
);
    import mips_pkg::*;

    cpu_state_e        state;
    logic              branch_pending;  // the instruction in EXEC is a delay slot
    logic [DATA_W-1:0] pending_target;
    logic [DATA_W-1:0] next_pc;
    logic              fetch_done;
    logic              mem_done;

    assign fetch_done = (state == FETCH) && !waitrequest;
    assign mem_done   = (state == MEM) && !waitrequest;

    // a delay slot hands over to the saved target, everything else falls through
    assign next_pc = branch_pending ? pending_target : pc + WORD_BYTES;

    // ######################################
    // state machine and program counter
    // ######################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= IDLE;
            pc             <= RESET_VECTOR;
            branch_pending <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    state <= FETCH;
                end
                FETCH: begin
                    if (fetch_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc             <= next_pc;
                    branch_pending <= take_branch;  // arms the slot after this one
                    if (is_load || is_store) begin
                        state <= MEM;
                    end else if (next_pc == HALT_ADDR) begin
                        state <= HALT;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM: begin
                    // pc was already moved in EXEC, so the halt check looks at it directly
                    if (mem_done) begin
                        state <= (pc == HALT_ADDR) ? HALT : FETCH;
                    end
                end
                HALT: begin
                    state <= HALT;  // only reset leaves this state
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= readdata;
        end
        if (state == EXEC && take_branch) begin
            pending_target <= branch_target;
        end
    end

    // ######################################
    // Avalon master and register write-back
    // ######################################

    assign active     = (state == FETCH) || (state == EXEC) || (state == MEM);
    assign read       = (state == FETCH) || ((state == MEM) && is_load);
    assign write      = (state == MEM) && is_store;
    assign address    = (state == FETCH) ? pc : mem_addr;
    assign writedata  = rt_val;         // SW stores rt
    assign byteenable = '1;             // word accesses only

    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];

    // ALU results land at the end of EXEC, load data when the read completes
    assign wr_en   = ((state == EXEC) && writes_reg && !is_load) || (mem_done && is_load);
    assign wr_idx  = dest_idx;
    assign wr_data = (state == MEM) ? readdata : alu_result;

    // ######################################
    // checks
    // ######################################

    assert property (@(posedge clk) disable iff (!rst_n) !(read && write));

    // a transfer held off by waitrequest keeps its address
    assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=> $stable(address));

endmodule

//--- design/mips_cpu.sv
module mips_cpu (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        active,
    output logic [mips_pkg::DATA_W-1:0] register_v0,
    output logic [mips_pkg::DATA_W-1:0] address,
    output logic                        read,
    output logic                        write,
    input  logic                        waitrequest,
    output logic [mips_pkg::DATA_W-1:0] writedata,
    output logic [mips_pkg::BE_W-1:0]   byteenable,
    input  logic [mips_pkg::DATA_W-1:0] readdata
);
    import mips_pkg::*;

    // register file ports
    logic [REG_IDX_W-1:0] rs_idx;
    logic [REG_IDX_W-1:0] rt_idx;
    logic [DATA_W-1:0]    rs_val;
    logic [DATA_W-1:0]    rt_val;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0]    wr_data;

    // decode results coming back from the datapath
    logic [DATA_W-1:0]    instr;
    logic [DATA_W-1:0]    pc;
    logic [DATA_W-1:0]    alu_result;
    logic [DATA_W-1:0]    mem_addr;
    logic [REG_IDX_W-1:0] dest_idx;
    logic                 writes_reg;
    logic                 is_load;
    logic                 is_store;
    logic                 take_branch;
    logic [DATA_W-1:0]    branch_target;

    cpu_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .dest_idx      (dest_idx),
        .writes_reg    (writes_reg),
        .is_load       (is_load),
        .is_store      (is_store),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .active        (active),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .instr         (instr),
        .pc            (pc),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .register_v0 (register_v0)
    );

    alu_branch u_alu_branch (
        .instr         (instr),
        .pc            (pc),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .dest_idx      (dest_idx),
        .writes_reg    (writes_reg),
        .is_load       (is_load),
        .is_store      (is_store),
        .take_branch   (take_branch),
        .branch_target (branch_target)
    );

endmodule

//--- dv/avalon_ram.sv
module avalon_ram (
    input  logic                        clk,
    input  logic [mips_pkg::DATA_W-1:0] address,
    input  logic                        read,
    input  logic                        write,
    input  logic [mips_pkg::DATA_W-1:0] writedata,
    input  logic [mips_pkg::BE_W-1:0]   byteenable,
    output logic                        waitrequest,
    output logic [mips_pkg::DATA_W-1:0] readdata,
    input  logic                        load_en,
    input  logic [mips_pkg::DATA_W-1:0] load_addr,
    input  logic [mips_pkg::DATA_W-1:0] load_data
);
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int WORD_AW = 8;  // 256 words, 1 KiB
    localparam int DEPTH   = 1 << WORD_AW;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [1:0]        stall_left;  // wait cycles still owed to the current transfer
    integer            seed;

    initial begin
        seed       = 32'h85df_d579;
        stall_left = 2'd0;
        // fill word carries its own byte address, and opcode 0x3c decodes as a NOP
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hf111_0000 | (i << 2);
        end
    end

    // ######################################
    // Avalon slave with random stalls
    // ######################################

    assign waitrequest = (read || write) && (stall_left != 2'd0);
    assign readdata    = mem[address[WORD_AW+1:2]];  // valid in the cycle the read completes

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[WORD_AW+1:2]] <= load_data;  // side port for program preload
        end
        if (read || write) begin
            if (stall_left != 2'd0) begin
                stall_left <= stall_left - 2'd1;
            end else begin
                // transfer completes now, so draw the stall for the next one
                stall_left <= $unsigned($random(seed)) % 3;
                if (write) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (byteenable[b]) begin
                            mem[address[WORD_AW+1:2]][8*b +: 8] <= writedata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- dv/mips_cpu_tb.sv
module mips_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int    CLK_PERIOD = 10;
    localparam string STIM_FILE  = "dv/blez_stim.txt";

    logic              clk;
    logic              rst_n;
    logic              active;
    logic [DATA_W-1:0] register_v0;
    logic [DATA_W-1:0] address;
    logic              read;
    logic              write;
    logic              waitrequest;
    logic [DATA_W-1:0] writedata;
    logic [BE_W-1:0]   byteenable;
    logic [DATA_W-1:0] readdata;
    logic              load_en;
    logic [DATA_W-1:0] load_addr;
    logic [DATA_W-1:0] load_data;

    // program table built from the stimulus file
    string             test_name [$];
    int                first_load [$];
    int                num_loads [$];
    logic [DATA_W-1:0] expected_v0 [$];
    int                cycle_limit [$];
    logic [DATA_W-1:0] load_addr_q [$];
    logic [DATA_W-1:0] load_word_q [$];

    int     error_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;
    bit     stim_ok;
    bit     watchdog_armed = 1'b0;
    longint watchdog_ns    = 0;

    mips_cpu UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_ram u_ram (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ######################################
    // helpers
    // ######################################

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic read_stimulus(output bit ok);
        int                fd;
        int                n;
        string             line;
        string             kind;
        string             name;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        int                limit;

        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", kind);
                if (n == 1 && kind == "p") begin
                    n = $sscanf(line, "%s %s", kind, name);
                    test_name.push_back(name);
                    first_load.push_back(load_addr_q.size());
                end else if (n == 1 && kind == "l") begin
                    n = $sscanf(line, "%s %h %h", kind, a, b);
                    load_addr_q.push_back(a);
                    load_word_q.push_back(b);
                end else if (n == 1 && kind == "e" && first_load.size() > 0) begin
                    n = $sscanf(line, "%s %h %d", kind, a, limit);
                    expected_v0.push_back(a);
                    cycle_limit.push_back(limit);
                    num_loads.push_back(load_addr_q.size() - first_load[first_load.size() - 1]);
                end
            end
            $fclose(fd);
            ok = (test_name.size() > 0) && (expected_v0.size() == test_name.size());
            if (!ok) begin
                $display("the stimulus file holds no complete program");
            end
        end
    endtask

    task automatic run_test(input int t);
        int i;
        int cycles;
        bit started;
        bit halted;
        int errors_before;

        errors_before = error_count;
        cycles        = 0;
        started       = 1'b0;
        halted        = 1'b0;

        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        for (i = first_load[t]; i < first_load[t] + num_loads[t]; i++) begin
            load_en   <= 1'b1;  // the core stays in reset while the program goes in
            load_addr <= load_addr_q[i];
            load_data <= load_word_q[i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        rst_n   <= 1'b1;

        // the run is over once active has risen and fallen again
        while (!halted && cycles < cycle_limit[t]) begin
            @(negedge clk);
            cycles++;
            if (active) begin
                started = 1'b1;
            end else if (started) begin
                halted = 1'b1;
            end
        end

        if (halted) begin
            check_value("register_v0", expected_v0[t], register_v0);
        end else begin
            $display("%s: the core did not halt within %0d cycles", test_name[t], cycle_limit[t]);
            error_count++;
        end

        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d %s: ok, halted after %0d cycles", t, test_name[t], cycles);
        end else begin
            fail_count++;
            $display("test %0d %s: FAIL", t, test_name[t]);
        end
    endtask

    // ######################################
    // main sequence
    // ######################################

    initial begin
        rst_n     <= 1'b0;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;

        read_stimulus(stim_ok);
        if (stim_ok) begin
            foreach (cycle_limit[i]) begin
                watchdog_ns += 3 * cycle_limit[i] * CLK_PERIOD;
            end
            watchdog_armed = 1'b1;
            foreach (test_name[t]) begin
                run_test(t);
            end
        end else begin
            fail_count++;
        end

        $display("%0d tests: %0d ok, %0d failed, %0d errors",
                 test_name.size(), pass_count, fail_count, error_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the cycle limits of all programs
    initial begin
        wait (watchdog_armed);
        #(watchdog_ns);
        $display("watchdog expired at %0t ns, the core never halted", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- dv/blez_stim.txt
# p <name> starts a program, l <byte address> <instruction word> preloads one RAM word (hex)
# e <expected v0 in hex> <cycle limit in decimal> ends the program
p blez_taken
l 00000004 24020010
l 00000008 18600002
l 0000000c 24420020
l 00000010 24420030
l 00000014 24420040
l 00000018 00000008
l 0000001c 00000000
e 00000070 60
p blez_not_taken
l 00000004 24030005
l 00000008 24020010
l 0000000c 18600002
l 00000010 24420020
l 00000014 24420030
l 00000018 24420040
l 0000001c 00000008
l 00000020 00000000
e 000000a0 60
p bgtz_loop
l 00000004 24030003
l 00000008 24420007
l 0000000c 2463ffff
l 00000010 1c60fffd
l 00000014 00000000
l 00000018 00000008
l 0000001c 00000000
e 00000015 100
p lw_sw_round_trip
l 00000004 24081234
l 00000008 24040200
l 0000000c ac880008
l 00000010 8c820008
l 00000014 00481021
l 00000018 24420001
l 0000001c 00000008
l 00000020 00000000
e 00002469 80
p addu_sll_zero_reg
l 00000004 24030003
l 00000008 00031100
l 0000000c 24000055
l 00000010 00401021
l 00000014 00431021
l 00000018 00020040
l 0000001c 00401021
l 00000020 00000008
l 00000024 00000000
e 00000033 80

//--- files.f
design/mips_pkg.sv
design/reg_file.sv
design/alu_branch.sv
design/cpu_control.sv
design/mips_cpu.sv
dv/avalon_ram.sv
dv/mips_cpu_tb.sv
